// ==== hdl/spi_pkg.sv ====
package spi_pkg;

   // Serial data word, also the width of the host data bus
   typedef logic [31:0] spi_data_t;

   // Register offset inside one channel
   typedef logic [1:0] spi_reg_addr_t;

   // Host address, bit 2 picks the channel
   typedef logic [2:0] spi_host_addr_t;

   // Serial clock period counter within a frame
   typedef logic [5:0] spi_frame_cnt_t;

   // Register map of one channel
   localparam spi_reg_addr_t SPI_ADDR_INTR_EN = 2'd0;
   localparam spi_reg_addr_t SPI_ADDR_READY   = 2'd1;
   localparam spi_reg_addr_t SPI_ADDR_TX      = 2'd2;
   localparam spi_reg_addr_t SPI_ADDR_RX      = 2'd3;

   // Slave select is low from period 16 through period 47
   localparam spi_frame_cnt_t SPI_SS_FIRST = 6'd16;
   localparam spi_frame_cnt_t SPI_SS_LAST  = 6'd47;

   // Counter parks here once the frame is over
   localparam spi_frame_cnt_t SPI_FRAME_LAST = 6'd63;

   // clk cycles per half period of sclk, must be 2 or more
   localparam int SCLK_HALF_DIV = 4;

   // Bus arbiter states
   typedef enum logic [1:0] {
      idle,
      busy_ch0,
      busy_ch1
   } arb_state_t;

endpackage

// ==== hdl/spi_port_if.sv ====
// Link between one master channel and the shared bus arbiter
interface spi_port_if;

   // Channel wants the bus for one frame
   logic req;
   // Bus is owned by this channel
   logic grant;
   // Per-channel slave select, active low
   logic ss;
   logic mosi;
   // Shared miso, forced to 0 unless granted
   logic miso;
   // One-cycle pulse when the low phase of ss is over
   logic done;

   modport master (
      output req,
      output ss,
      output mosi,
      input  grant,
      input  miso,
      input  done
   );

   modport arbiter (
      input  req,
      input  ss,
      input  mosi,
      output grant,
      output miso,
      output done
   );

endinterface

// ==== hdl/spi_clk_gen.sv ====
module spi_clk_gen (
   input  logic clk,
   input  logic rst,
   output logic sclk,
   output logic sclk_fall
);

   logic [$clog2(spi_pkg::SCLK_HALF_DIV)-1:0] div_cnt;
   logic                                      half_end;

   // Last clk cycle of the current sclk half period
   assign half_end = (div_cnt == $bits(div_cnt)'(spi_pkg::SCLK_HALF_DIV - 1));

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         div_cnt <= '0;
      end else if (half_end) begin
         div_cnt <= '0;
      end else begin
         div_cnt <= div_cnt + 1'b1;
      end
   end

   // sclk level, starts low out of reset
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         sclk <= 1'b0;
      end else if (half_end) begin
         sclk <= ~sclk;
      end
   end

   // High in the cycle whose closing edge takes sclk from 1 to 0,
   // so logic clocked by this strobe moves together with the falling edge
   assign sclk_fall = sclk & half_end;

endmodule

// ==== hdl/spi_master.sv ====
module spi_master (
   input  logic               clk,
   input  logic               rst,
   input  logic               sclk_fall,
   input  logic               sel,
   input  logic               we,
   input  spi_pkg::spi_reg_addr_t address,
   input  spi_pkg::spi_data_t     data_in,
   output spi_pkg::spi_data_t     data_out,
   output logic               interrupt,
   spi_port_if.master         port
);

   // Register side
   logic tx_wr;
   logic tx_start;
   logic rx_rd;
   logic intr_en_wr;
   logic intr_en;
   logic ready;

   // Serial side
   spi_pkg::spi_frame_cnt_t frame_cnt;
   logic                    active;
   logic                    ss_low;
   spi_pkg::spi_data_t      tx_shift;
   spi_pkg::spi_data_t      rx_shift;

   // Address decoder
   always_comb begin
      tx_wr      = 1'b0;
      rx_rd      = 1'b0;
      intr_en_wr = 1'b0;
      data_out   = '0;
      case (address)
         spi_pkg::SPI_ADDR_INTR_EN: begin
            intr_en_wr = sel & we;
         end
         spi_pkg::SPI_ADDR_READY: begin
            data_out = {30'd0, port.req, ready};
         end
         spi_pkg::SPI_ADDR_TX: begin
            tx_wr = sel & we;
         end
         spi_pkg::SPI_ADDR_RX: begin
            data_out = rx_shift;
            rx_rd    = sel & ~we;
         end
         default: begin
            data_out = '0;
         end
      endcase
   end

   // Writes to TX while a frame is pending or running are dropped
   assign tx_start = tx_wr & ~port.req;

   // Transmit word goes straight into the shift register
   always_ff @(posedge clk) begin
      if (tx_start) begin
         tx_shift <= data_in;
      end else if (sclk_fall && ss_low) begin
         tx_shift <= tx_shift >> 1;
      end
   end

   // LSB first, miso enters at the top
   always_ff @(posedge clk) begin
      if (sclk_fall && ss_low) begin
         rx_shift <= {port.miso, rx_shift[31:1]};
      end
   end

   // Bus request, dropped once the frame tail is over
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         port.req <= 1'b0;
      end else if (tx_start) begin
         port.req <= 1'b1;
      end else if (active && frame_cnt == spi_pkg::SPI_FRAME_LAST) begin
         port.req <= 1'b0;
      end
   end

   // Frame counter
   // Period 0 begins at the first falling sclk edge after grant
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         active    <= 1'b0;
         frame_cnt <= '0;
      end else if (!active) begin
         if (sclk_fall && port.grant && port.req) begin
            active    <= 1'b1;
            frame_cnt <= '0;
         end
      end else if (frame_cnt == spi_pkg::SPI_FRAME_LAST) begin
         active <= 1'b0;
      end else if (sclk_fall) begin
         frame_cnt <= frame_cnt + 1'b1;
      end
   end

   assign ss_low = active &&
                   (frame_cnt >= spi_pkg::SPI_SS_FIRST) &&
                   (frame_cnt <= spi_pkg::SPI_SS_LAST);

   assign port.ss   = ~ss_low;
   // Quiet line outside the data phase
   assign port.mosi = ss_low & tx_shift[0];

   // Ready flag
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         ready <= 1'b0;
      end else if (port.done) begin
         ready <= 1'b1;
      end else if (tx_start || rx_rd) begin
         ready <= 1'b0;
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         intr_en <= 1'b0;
      end else if (intr_en_wr) begin
         intr_en <= data_in[0];
      end
   end

   assign interrupt = intr_en & ready;

endmodule

// ==== hdl/spi_bus_arbiter.sv ====
module spi_bus_arbiter (
   input  logic        clk,
   input  logic        rst,
   spi_port_if.arbiter port_0,
   spi_port_if.arbiter port_1,
   output logic        mosi,
   input  logic        miso
);

   spi_pkg::arb_state_t state;
   spi_pkg::arb_state_t state_next;
   // 1 when channel 1 held the bus last
   logic                last_owner;
   logic                ss_0_q;
   logic                ss_1_q;

   // Owner selection, alternating on collisions
   always_comb begin
      state_next = state;
      unique case (state)
         spi_pkg::idle: begin
            if (port_0.req && port_1.req) begin
               state_next = last_owner ? spi_pkg::busy_ch0 : spi_pkg::busy_ch1;
            end else if (port_0.req) begin
               state_next = spi_pkg::busy_ch0;
            end else if (port_1.req) begin
               state_next = spi_pkg::busy_ch1;
            end
         end
         spi_pkg::busy_ch0: begin
            if (!port_0.req) begin
               state_next = spi_pkg::idle;
            end
         end
         spi_pkg::busy_ch1: begin
            if (!port_1.req) begin
               state_next = spi_pkg::idle;
            end
         end
         default: begin
            state_next = spi_pkg::idle;
         end
      endcase
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state      <= spi_pkg::idle;
         last_owner <= 1'b1;
      end else begin
         state <= state_next;
         if (state == spi_pkg::busy_ch0 && !port_0.req) begin
            last_owner <= 1'b0;
         end else if (state == spi_pkg::busy_ch1 && !port_1.req) begin
            last_owner <= 1'b1;
         end
      end
   end

   // Previous ss levels for the end-of-data detection
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         ss_0_q <= 1'b1;
         ss_1_q <= 1'b1;
      end else begin
         ss_0_q <= port_0.ss;
         ss_1_q <= port_1.ss;
      end
   end

   // Grant drops in the same cycle as req
   assign port_0.grant = (state == spi_pkg::busy_ch0) & port_0.req;
   assign port_1.grant = (state == spi_pkg::busy_ch1) & port_1.req;

   // ss rising edge of the owner
   assign port_0.done = (state == spi_pkg::busy_ch0) & port_0.ss & ~ss_0_q;
   assign port_1.done = (state == spi_pkg::busy_ch1) & port_1.ss & ~ss_1_q;

   assign port_0.miso = (state == spi_pkg::busy_ch0) & miso;
   assign port_1.miso = (state == spi_pkg::busy_ch1) & miso;

   always_comb begin
      case (state)
         spi_pkg::busy_ch0: mosi = port_0.mosi;
         spi_pkg::busy_ch1: mosi = port_1.mosi;
         default:           mosi = 1'b0;
      endcase
   end

endmodule

// ==== hdl/spi_subsys_top.sv ====
module spi_subsys_top (
   input  logic                    clk,
   input  logic                    rst,
   // Host side
   input  logic                    sel,
   input  logic                    we,
   input  spi_pkg::spi_host_addr_t address,
   input  spi_pkg::spi_data_t      data_in,
   output spi_pkg::spi_data_t      data_out,
   output logic                    interrupt_0,
   output logic                    interrupt_1,
   // Shared SPI bus
   output logic                    sclk,
   output logic                    mosi,
   input  logic                    miso,
   output logic                    ss_0,
   output logic                    ss_1
);

   logic                   sclk_fall;
   logic                   sel_0;
   logic                   sel_1;
   spi_pkg::spi_reg_addr_t reg_addr;
   spi_pkg::spi_data_t     data_out_0;
   spi_pkg::spi_data_t     data_out_1;

   spi_port_if port_0_if ();
   spi_port_if port_1_if ();

   // Channel select from address bit 2
   assign sel_0    = sel & ~address[2];
   assign sel_1    = sel & address[2];
   assign reg_addr = address[1:0];
   assign data_out = address[2] ? data_out_1 : data_out_0;

   assign ss_0 = port_0_if.ss;
   assign ss_1 = port_1_if.ss;

   spi_clk_gen clk_gen_inst (
      .clk       (clk),
      .rst       (rst),
      .sclk      (sclk),
      .sclk_fall (sclk_fall)
   );

   spi_master ch0 (
      .clk       (clk),
      .rst       (rst),
      .sclk_fall (sclk_fall),
      .sel       (sel_0),
      .we        (we),
      .address   (reg_addr),
      .data_in   (data_in),
      .data_out  (data_out_0),
      .interrupt (interrupt_0),
      .port      (port_0_if.master)
   );

   spi_master ch1 (
      .clk       (clk),
      .rst       (rst),
      .sclk_fall (sclk_fall),
      .sel       (sel_1),
      .we        (we),
      .address   (reg_addr),
      .data_in   (data_in),
      .data_out  (data_out_1),
      .interrupt (interrupt_1),
      .port      (port_1_if.master)
   );

   spi_bus_arbiter arbiter_inst (
      .clk    (clk),
      .rst    (rst),
      .port_0 (port_0_if.arbiter),
      .port_1 (port_1_if.arbiter),
      .mosi   (mosi),
      .miso   (miso)
   );

endmodule

// ==== dv/spi_slave_model.sv ====
module spi_slave_model #(
   parameter logic [31:0] INIT_WORD = 32'd0
) (
   input  logic        sclk,
   input  logic        ss,
   input  logic        mosi,
   output wire         miso,
   output logic [31:0] captured
);

   logic [31:0] shift_in;
   // Sent back in the current frame, the capture of the frame before
   logic [31:0] out_word = INIT_WORD;
   logic        miso_q   = 1'b0;
   int          bit_idx  = 0;

   // Line released outside the select window
   assign miso = ss ? 1'bz : miso_q;

   always @(negedge ss) begin
      bit_idx = 0;
   end

   // mosi moves on the falling edge, so it is settled at the rising edge
   always @(posedge sclk) begin
      if (!ss && bit_idx < 32) begin
         shift_in[bit_idx] = mosi;
         miso_q            = out_word[bit_idx];
         bit_idx++;
      end
   end

   // Full word seen, keep it for the next frame
   always @(posedge ss) begin
      if (bit_idx == 32) begin
         captured = shift_in;
         out_word = shift_in;
         bit_idx  = 0;
      end
   end

endmodule

// ==== dv/tb_spi_subsys.sv ====
module tb_spi_subsys;

   localparam int CLK_PERIOD             = 20;
   localparam int FRAME_CYCLES           = 128 * spi_pkg::SCLK_HALF_DIV;
   localparam int POLL_LIMIT             = 2 * FRAME_CYCLES;
   localparam spi_pkg::spi_data_t INIT_0 = 32'hA5C3_0F18;
   localparam spi_pkg::spi_data_t INIT_1 = 32'h3C96_E14B;

   logic                    clk = 1'b0;
   logic                    rst;
   logic                    sel;
   logic                    we;
   spi_pkg::spi_host_addr_t address;
   spi_pkg::spi_data_t      data_in;
   spi_pkg::spi_data_t      data_out;
   logic                    interrupt_0;
   logic                    interrupt_1;
   logic                    sclk;
   logic                    mosi;
   tri0                     miso;
   logic                    ss_0;
   logic                    ss_1;
   spi_pkg::spi_data_t      captured_0;
   spi_pkg::spi_data_t      captured_1;
   logic [1:0]              en_exp;
   spi_pkg::spi_data_t      prev_word [2];
   logic [31:0]             lfsr = 32'd3420;
   int                      frame_order [$];
   logic                    sclk_q = 1'b0;
   int                      sclk_hold = 0;
   int                      checks = 0;
   int                      errors = 0;

   always #(CLK_PERIOD / 2) clk = ~clk;

   spi_subsys_top spi_subsys_top_inst (.*);

   spi_slave_model #(.INIT_WORD(INIT_0)) slave_0 (
      .sclk(sclk), .ss(ss_0), .mosi(mosi), .miso(miso), .captured(captured_0)
   );
   spi_slave_model #(.INIT_WORD(INIT_1)) slave_1 (
      .sclk(sclk), .ss(ss_1), .mosi(mosi), .miso(miso), .captured(captured_1)
   );

   // Order in which frames start on the shared bus
   always @(negedge ss_0) frame_order.push_back(0);
   always @(negedge ss_1) frame_order.push_back(1);

   always @(negedge clk) begin
      if (rst === 1'b0) begin
         assert (ss_0 || ss_1) else begin
            errors++;
            $display("ss_0 and ss_1 are low in the same cycle");
         end
      end
   end

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      checks++;
      assert (actual === expected) else begin
         errors++;
         $display("mismatch %s expected %h actual %h", name, expected, actual);
      end
   endtask

   // Each sclk level lasts SCLK_HALF_DIV clk cycles
   always @(negedge clk) begin
      if (rst === 1'b0) begin
         if (sclk !== sclk_q) begin
            check_value("sclk half period", spi_pkg::SCLK_HALF_DIV, sclk_hold);
            sclk_hold = 1;
         end else begin
            sclk_hold++;
         end
         sclk_q = sclk;
      end
   end

   // Galois LFSR, one step per bit taken
   function automatic spi_pkg::spi_data_t next_word();
      spi_pkg::spi_data_t word;
      for (int i = 0; i < 32; i++) begin
         lfsr    = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
         word[i] = lfsr[0];
      end
      return word;
   endfunction

   task automatic reg_write(input logic ch, input spi_pkg::spi_reg_addr_t reg_addr,
                            input spi_pkg::spi_data_t value);
      @(posedge clk);
      #2;
      sel     = 1'b1;
      we      = 1'b1;
      address = {ch, reg_addr};
      data_in = value;
      @(posedge clk);
      #2;
      sel = 1'b0;
      we  = 1'b0;
   endtask

   // Sampled mid cycle, the read side effect lands on the next edge
   task automatic reg_read(input logic ch, input spi_pkg::spi_reg_addr_t reg_addr,
                           output spi_pkg::spi_data_t value);
      @(posedge clk);
      #2;
      sel     = 1'b1;
      we      = 1'b0;
      address = {ch, reg_addr};
      @(negedge clk);
      value = data_out;
      @(posedge clk);
      #2;
      sel = 1'b0;
   endtask

   task automatic wait_status(input logic ch, input spi_pkg::spi_data_t expected);
      spi_pkg::spi_data_t value;
      int                 polls;
      polls = 0;
      reg_read(ch, spi_pkg::SPI_ADDR_READY, value);
      while (value !== expected && polls < POLL_LIMIT) begin
         reg_read(ch, spi_pkg::SPI_ADDR_READY, value);
         polls++;
      end
      assert (value === expected) else begin
         errors++;
         $display("channel %0d READY never reached %0d", ch, expected);
      end
   endtask

   task automatic start_frame(input logic ch, input spi_pkg::spi_data_t word);
      spi_pkg::spi_data_t value;
      reg_write(ch, spi_pkg::SPI_ADDR_TX, word);
      reg_read(ch, spi_pkg::SPI_ADDR_READY, value);
      check_value("busy after tx", 32'd2, value);
   endtask

   // Ready with the tail still running, then RX read
   task automatic check_frame(input logic ch, input spi_pkg::spi_data_t word);
      spi_pkg::spi_data_t value;
      wait_status(ch, 32'd3);
      check_value("tx capture", word, ch ? captured_1 : captured_0);
      check_value("interrupt set", {31'd0, en_exp[ch]}, {31'd0, ch ? interrupt_1 : interrupt_0});
      reg_read(ch, spi_pkg::SPI_ADDR_RX, value);
      check_value("rx data", prev_word[ch], value);
      prev_word[ch] = word;
      check_value("interrupt clear", 32'd0, {31'd0, ch ? interrupt_1 : interrupt_0});
      reg_read(ch, spi_pkg::SPI_ADDR_READY, value);
      check_value("ready clear", 32'd2, value);
   endtask

   // TX write held on ch until the other channel starts its frame,
   // so it is taken in the first cycle after ch drops req
   task automatic rewrite_tx_on_release(input logic ch, input spi_pkg::spi_data_t word);
      int cycles;
      cycles = 0;
      @(posedge clk);
      #2;
      sel     = 1'b1;
      we      = 1'b1;
      address = {ch, spi_pkg::SPI_ADDR_TX};
      data_in = word;
      while ((ch ? ss_0 : ss_1) !== 1'b0 && cycles < POLL_LIMIT) begin
         @(posedge clk);
         #2;
         cycles++;
      end
      sel = 1'b0;
      we  = 1'b0;
      assert (cycles < POLL_LIMIT) else begin
         errors++;
         $display("channel %0d never got the bus after channel %0d", !ch, ch);
      end
   endtask

   initial begin
      #(40 * FRAME_CYCLES * CLK_PERIOD + 100 * CLK_PERIOD);
      $display("watchdog expired, checks %0d errors %0d", checks, errors);
      $display("Something failed");
      $finish;
   end

   initial begin
      spi_pkg::spi_data_t value;
      spi_pkg::spi_data_t word_a;
      spi_pkg::spi_data_t word_b;
      spi_pkg::spi_data_t pend_word [2];
      logic               owner;
      rst          = 1'b1;
      sel          = 1'b0;
      we           = 1'b0;
      address      = '0;
      data_in      = '0;
      prev_word[0] = INIT_0;
      prev_word[1] = INIT_1;
      repeat (4) @(posedge clk);
      #2;
      rst = 1'b0;
      check_value("reset ss", 32'd3, {30'd0, ss_1, ss_0});
      check_value("reset mosi", 32'd0, {31'd0, mosi});
      check_value("reset interrupt", 32'd0, {30'd0, interrupt_1, interrupt_0});
      reg_read(1'b0, spi_pkg::SPI_ADDR_READY, value);
      check_value("reset ready", 32'd0, value);
      reg_read(1'b1, spi_pkg::SPI_ADDR_READY, value);
      check_value("reset ready", 32'd0, value);
      // Interrupt off on channel 0, on for channel 1
      reg_write(1'b0, spi_pkg::SPI_ADDR_INTR_EN, 32'd0);
      reg_write(1'b1, spi_pkg::SPI_ADDR_INTR_EN, 32'd1);
      en_exp = 2'b10;
      for (int ch = 0; ch < 2; ch++) begin
         word_a = next_word();
         start_frame(ch, word_a);
         check_frame(ch, word_a);
         wait_status(ch, 32'd0);
      end
      // Second TX write while busy must be dropped
      word_a = next_word();
      word_b = next_word();
      start_frame(1'b0, word_a);
      reg_write(1'b0, spi_pkg::SPI_ADDR_TX, word_b);
      check_frame(1'b0, word_a);
      wait_status(1'b0, 32'd0);
      // Enables swapped, so each pin is seen with enable on and off
      reg_write(1'b0, spi_pkg::SPI_ADDR_INTR_EN, 32'd1);
      reg_write(1'b1, spi_pkg::SPI_ADDR_INTR_EN, 32'd0);
      en_exp = 2'b01;
      // Back to back writes, then each finished channel asks again at once
      // and meets the waiting channel in the idle cycle
      pend_word[0] = next_word();
      pend_word[1] = next_word();
      frame_order.delete();
      start_frame(1'b0, pend_word[0]);
      start_frame(1'b1, pend_word[1]);
      for (int r = 0; r < 4; r++) begin
         owner = r[0];
         check_frame(owner, pend_word[owner]);
         pend_word[owner] = next_word();
         rewrite_tx_on_release(owner, pend_word[owner]);
      end
      check_frame(1'b0, pend_word[0]);
      wait_status(1'b0, 32'd0);
      check_frame(1'b1, pend_word[1]);
      wait_status(1'b1, 32'd0);
      check_value("frame count", 32'd6, frame_order.size());
      for (int i = 0; i < frame_order.size(); i++) begin
         check_value("frame order", i % 2, frame_order[i]);
      end
      $display("checks %0d errors %0d", checks, errors);
      if (errors == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

endmodule

// ==== spi_subsys_top.f ====
hdl/spi_pkg.sv
hdl/spi_port_if.sv
hdl/spi_clk_gen.sv
hdl/spi_master.sv
hdl/spi_bus_arbiter.sv
hdl/spi_subsys_top.sv
dv/spi_slave_model.sv
dv/tb_spi_subsys.sv

// ==== Bender.yml ====
package:
  name: spi_subsys

sources:
  - hdl/spi_pkg.sv
  - hdl/spi_port_if.sv
  - hdl/spi_clk_gen.sv
  - hdl/spi_master.sv
  - hdl/spi_bus_arbiter.sv
  - hdl/spi_subsys_top.sv
  - target: test
    files:
      - dv/spi_slave_model.sv
      - dv/tb_spi_subsys.sv
